//--- src/ice51_pkg.sv
package ice51_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // uart timing and code memory

   localparam int BIT_CYCLES = 104;               // clocks per serial bit
   localparam int BIT_CW     = $clog2(BIT_CYCLES);
   localparam int CODE_WORDS = 64;                // boot image length
   localparam int CODE_AW    = $clog2(CODE_WORDS);

   // loader receive states
   localparam logic [1:0] RX_IDLE  = 2'b00;
   localparam logic [1:0] RX_START = 2'b01;
   localparam logic [1:0] RX_DATA  = 2'b11;
   localparam logic [1:0] RX_STOP  = 2'b10;

   // movx register map
   localparam logic [15:0] TX_STAT_ADDR = 16'h0200;
   localparam logic [15:0] TX_DATA_ADDR = 16'h0201;

   ////////////////////////////////////////////////////////////////////////////
   // opcodes

   localparam logic [7:0] OP_INCA   = 8'h04;
   localparam logic [7:0] OP_DECA   = 8'h14;
   localparam logic [7:0] OP_RL     = 8'h23;
   localparam logic [7:0] OP_ADDAI  = 8'h24;  // add a,#imm
   localparam logic [7:0] OP_JC     = 8'h40;
   localparam logic [7:0] OP_ORLA   = 8'h44;  // orl a,#imm
   localparam logic [7:0] OP_JNC    = 8'h50;
   localparam logic [7:0] OP_ANLAI  = 8'h54;
   localparam logic [7:0] OP_JZ     = 8'h60;
   localparam logic [7:0] OP_XRLA   = 8'h64;  // xrl a,#imm
   localparam logic [7:0] OP_JNZ    = 8'h70;
   localparam logic [7:0] OP_MOVAI  = 8'h74;
   localparam logic [7:0] OP_SJMP   = 8'h80;
   localparam logic [7:0] OP_MOVDP  = 8'h90;  // mov dptr,#imm16
   localparam logic [7:0] OP_CLRC   = 8'hC3;
   localparam logic [7:0] OP_SWAP   = 8'hC4;
   localparam logic [7:0] OP_SETBC  = 8'hD3;
   localparam logic [7:0] OP_MOVXAD = 8'hE0;  // movx a,@dptr
   localparam logic [7:0] OP_CLRA   = 8'hE4;
   localparam logic [7:0] OP_MOVXDA = 8'hF0;  // movx @dptr,a
   localparam logic [7:0] OP_CPLA   = 8'hF4;

   // core sequencing
   typedef enum logic [2:0] {
      ST_FETCH   = 3'd0,
      ST_DECODE0 = 3'd1,
      ST_DECODE1 = 3'd2,
      ST_DECODE2 = 3'd3,
      ST_EXECUTE = 3'd4
   } cpu_state_t;

endpackage

//--- src/cpu_if.sv
`timescale 1ns/1ns

interface cpu_if;
   logic [7:0] op;       // latched opcode
   logic [7:0] h_data;   // first operand byte
   logic [7:0] l_data;   // second operand byte
   logic       exec;
   logic       hold;     // stretch execute
   logic       acc_zero;
   logic       carry;

   modport seq (
      output op,
      output h_data,
      output l_data,
      output exec,
      input  hold,
      input  acc_zero,
      input  carry
   );

   modport dp (
      input  op,
      input  h_data,
      input  l_data,
      input  exec,
      output hold,
      output acc_zero,
      output carry
   );
endinterface

//--- src/uart_loader.sv
`timescale 1ns/1ns

module uart_loader (
   input  logic                          i_clk,
   input  logic                          i_nrst,
   input  logic                          i_uart_rx,
   output logic                          o_code_wr,
   output logic [ice51_pkg::CODE_AW-1:0] o_code_addr,
   output logic [7:0]                    o_code_wdata,
   output logic                          o_load_done
);
   import ice51_pkg::*;

   logic [1:0]         rx_sync;     // two flop resync
   logic               rx;
   logic [1:0]         rx_state;
   logic [BIT_CW-1:0]  smp_cnt;
   logic [7:0]         rx_data;
   logic [CODE_AW-1:0] byte_cnt;
   logic               half_bit;
   logic               full_bit;
   logic               stop_seen;

   assign rx        = rx_sync[1];
   assign half_bit  = smp_cnt == BIT_CW'(BIT_CYCLES / 2 - 1);
   assign full_bit  = smp_cnt == BIT_CW'(BIT_CYCLES - 1);
   assign stop_seen = (rx_state == RX_STOP) && full_bit;

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         rx_sync  <= 2'b11;
         rx_state <= RX_IDLE;
         smp_cnt  <= '0;
      end else begin
         rx_sync <= {rx_sync[0], i_uart_rx};
         smp_cnt <= smp_cnt + 1'b1;
         case (rx_state)
            RX_IDLE: begin
               smp_cnt <= '0;
               if (!rx) rx_state <= RX_START;        // falling edge of start bit
            end
            RX_START: begin
               if (half_bit) begin                   // middle of start bit
                  smp_cnt  <= '0;
                  rx_state <= RX_DATA;
               end
            end
            RX_DATA: begin
               if (full_bit) begin
                  smp_cnt <= '0;
                  if (rx_data[0]) rx_state <= RX_STOP;  // marker reached bit 0
               end
            end
            default: begin
               if (full_bit) rx_state <= RX_IDLE;
            end
         endcase
      end
   end

   // marker bit walks down as the data bits shift in, lsb first
   always_ff @(posedge i_clk) begin
      if (rx_state == RX_IDLE && !rx) rx_data <= 8'h80;
      else if (rx_state == RX_DATA && full_bit) rx_data <= {rx, rx_data[7:1]};
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         o_code_wr   <= 1'b0;
         byte_cnt    <= '0;
         o_load_done <= 1'b0;
      end else begin
         o_code_wr <= stop_seen;
         if (o_code_wr) byte_cnt <= byte_cnt + 1'b1;
         if (stop_seen && byte_cnt == CODE_AW'(CODE_WORDS - 1)) o_load_done <= 1'b1;
      end
   end

   assign o_code_addr  = byte_cnt;
   assign o_code_wdata = rx_data;

   // host sends exactly one image per reset
   a_no_write_after_done: assert property (
      @(posedge i_clk) disable iff (!i_nrst) o_load_done |=> !o_code_wr
   ) else $error("code write after load_done");

endmodule

//--- src/code_ram.sv
`timescale 1ns/1ns

module code_ram (
   input  logic                          i_clk,
   input  logic                          i_wr,
   input  logic [ice51_pkg::CODE_AW-1:0] i_waddr,
   input  logic [7:0]                    i_wdata,
   input  logic [ice51_pkg::CODE_AW-1:0] i_raddr,
   output logic [7:0]                    o_rdata
);
   import ice51_pkg::*;

   logic [7:0] mem [CODE_WORDS];

   // written only by the loader
   always_ff @(posedge i_clk) begin
      if (i_wr) mem[i_waddr] <= i_wdata;
   end

   // data shows up one cycle after the address
   always_ff @(posedge i_clk) begin
      o_rdata <= mem[i_raddr];
   end

endmodule

//--- src/cpu_sequencer.sv
`timescale 1ns/1ns

module cpu_sequencer (
   input  logic                          i_clk,
   input  logic                          i_nrst,
   input  logic                          i_load_done,
   output logic [ice51_pkg::CODE_AW-1:0] o_code_addr,
   input  logic [7:0]                    i_code_rdata,
   cpu_if.seq                            bus
);
   import ice51_pkg::*;

   cpu_state_t         state;
   cpu_state_t         state_next;
   logic [CODE_AW-1:0] pc;
   logic [CODE_AW-1:0] pc_next;
   logic [7:0]         op_q;
   logic [7:0]         h_q;
   logic [7:0]         l_q;
   logic               take;        // branch taken in execute

   function automatic logic has_operand(input logic [7:0] op);
      case (op)
         OP_ADDAI, OP_ANLAI, OP_ORLA, OP_XRLA, OP_MOVAI,
         OP_JC, OP_JNC, OP_JZ, OP_JNZ, OP_SJMP, OP_MOVDP: has_operand = 1'b1;
         default: has_operand = 1'b0;
      endcase
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // state

   always_comb begin
      state_next = state;
      case (state)
         ST_FETCH:   if (i_load_done) state_next = ST_DECODE0;
         ST_DECODE0: state_next = has_operand(i_code_rdata) ? ST_DECODE1 : ST_EXECUTE;
         ST_DECODE1: state_next = (op_q == OP_MOVDP) ? ST_DECODE2 : ST_EXECUTE;
         ST_DECODE2: state_next = ST_EXECUTE;
         ST_EXECUTE: if (!bus.hold) state_next = ST_FETCH;
         default:    state_next = ST_FETCH;
      endcase
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) state <= ST_FETCH;
      else state <= state_next;
   end

   // opcode and operands, one byte per decode cycle
   always_ff @(posedge i_clk) begin
      if (state == ST_DECODE0) op_q <= i_code_rdata;
      if (state == ST_DECODE1) h_q <= i_code_rdata;
      if (state == ST_DECODE2) l_q <= i_code_rdata;
   end

   ////////////////////////////////////////////////////////////////////////////
   // program counter

   always_comb begin
      case (op_q)
         OP_SJMP: take = 1'b1;
         OP_JZ:   take = bus.acc_zero;
         OP_JNZ:  take = ~bus.acc_zero;
         OP_JC:   take = bus.carry;
         OP_JNC:  take = ~bus.carry;
         default: take = 1'b0;
      endcase
   end

   // pc steps once per byte read, so in execute it already points past the
   // instruction; low bits of rel are enough since pc wraps at CODE_AW
   always_comb begin
      pc_next = pc;
      if (state_next inside {ST_DECODE0, ST_DECODE1, ST_DECODE2}) begin
         pc_next = pc + 1'b1;
      end else if (state == ST_EXECUTE && !bus.hold && take) begin
         pc_next = pc + h_q[CODE_AW-1:0];
      end
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) pc <= '0;
      else pc <= pc_next;
   end

   assign o_code_addr = pc;
   assign bus.op      = op_q;
   assign bus.h_data  = h_q;
   assign bus.l_data  = l_q;
   assign bus.exec    = state == ST_EXECUTE;

   a_state_legal: assert property (
      @(posedge i_clk) disable iff (!i_nrst)
      state inside {ST_FETCH, ST_DECODE0, ST_DECODE1, ST_DECODE2, ST_EXECUTE}
   ) else $error("illegal core state %0d", state);

endmodule

//--- src/cpu_datapath.sv
`timescale 1ns/1ns

module cpu_datapath (
   input  logic       i_clk,
   input  logic       i_nrst,
   cpu_if.dp          bus,
   output logic       o_tx_valid,
   output logic [7:0] o_tx_data,
   input  logic       i_tx_ready
);
   import ice51_pkg::*;

   logic [7:0]  acc;
   logic [7:0]  acc_next;
   logic        carry;
   logic        carry_next;
   logic [15:0] dptr;
   logic [8:0]  sum;            // add with carry out in bit 8
   logic        tx_wr;          // movx write aimed at the transmitter
   logic        tx_take;

   assign sum     = {1'b0, acc} + {1'b0, bus.h_data};
   assign tx_wr   = (bus.op == OP_MOVXDA) && (dptr == TX_DATA_ADDR);
   assign tx_take = o_tx_valid & i_tx_ready;

   // stall until the transmitter has the byte
   assign bus.hold     = bus.exec & tx_wr & ~tx_take;
   assign bus.acc_zero = acc == 8'h00;
   assign bus.carry    = carry;

   ////////////////////////////////////////////////////////////////////////////
   // alu

   always_comb begin
      acc_next   = acc;
      carry_next = carry;
      case (bus.op)
         OP_INCA:  acc_next = acc + 8'd1;          // carry untouched
         OP_DECA:  acc_next = acc - 8'd1;
         OP_RL:    acc_next = {acc[6:0], acc[7]};
         OP_ADDAI: begin
            acc_next   = sum[7:0];
            carry_next = sum[8];
         end
         OP_ANLAI: acc_next = acc & bus.h_data;
         OP_ORLA:  acc_next = acc | bus.h_data;
         OP_XRLA:  acc_next = acc ^ bus.h_data;
         OP_MOVAI: acc_next = bus.h_data;
         OP_SWAP:  acc_next = {acc[3:0], acc[7:4]};
         OP_CLRA:  acc_next = 8'h00;
         OP_CPLA:  acc_next = ~acc;
         OP_SETBC: carry_next = 1'b1;
         OP_CLRC:  carry_next = 1'b0;
         OP_MOVXAD: begin
            // only the status register reads back
            acc_next = (dptr == TX_STAT_ADDR) ? {7'd0, ~i_tx_ready} : 8'h00;
         end
         default: ;                                 // unknown op is a nop
      endcase
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         acc   <= 8'h00;
         carry <= 1'b0;
         dptr  <= 16'h0000;
      end else if (bus.exec) begin
         acc   <= acc_next;
         carry <= carry_next;
         if (bus.op == OP_MOVDP) dptr <= {bus.h_data, bus.l_data};  // high byte first
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // transmit handshake

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         o_tx_valid <= 1'b0;
      end else if (tx_take) begin
         o_tx_valid <= 1'b0;
      end else if (bus.exec && tx_wr) begin
         o_tx_valid <= 1'b1;
      end
   end

   always_ff @(posedge i_clk) begin
      if (bus.exec && tx_wr) o_tx_data <= acc;  // acc frozen while execute stalls
   end

   a_tx_stable: assert property (
      @(posedge i_clk) disable iff (!i_nrst)
      o_tx_valid && !i_tx_ready |=> o_tx_valid && $stable(o_tx_data)
   ) else $error("tx byte changed while waiting for ready");

endmodule

//--- src/uart_tx.sv
`timescale 1ns/1ns

module uart_tx (
   input  logic       i_clk,
   input  logic       i_nrst,
   input  logic       i_tx_valid,
   input  logic [7:0] i_tx_data,
   output logic       o_tx_ready,
   output logic       o_uart_tx
);
   import ice51_pkg::*;

   logic [3:0]        bit_cnt;     // bits left in the frame
   logic [BIT_CW-1:0] smp_cnt;
   logic [9:0]        shreg;       // stop, data, start, shifted out from bit 0
   logic              bit_end;

   assign o_tx_ready = bit_cnt == 4'd0;
   assign bit_end    = smp_cnt == BIT_CW'(BIT_CYCLES - 1);
   assign o_uart_tx  = shreg[0];   // ones fill in behind the stop bit

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         bit_cnt <= 4'd0;
         smp_cnt <= '0;
         shreg   <= '1;
      end else if (i_tx_valid && o_tx_ready) begin
         bit_cnt <= 4'd10;
         smp_cnt <= '0;
         shreg   <= {1'b1, i_tx_data, 1'b0};
      end else if (!o_tx_ready) begin
         if (bit_end) begin
            smp_cnt <= '0;
            bit_cnt <= bit_cnt - 4'd1;
            shreg   <= {1'b1, shreg[9:1]};  // lsb first
         end else begin
            smp_cnt <= smp_cnt + 1'b1;
         end
      end
   end

   // counter and shift register must agree on an idle line
   a_idle_high: assert property (
      @(posedge i_clk) disable iff (!i_nrst) o_tx_ready |-> o_uart_tx
   ) else $error("tx line low while ready");

endmodule

//--- src/ice51_top.sv
`timescale 1ns/1ns

module ice51_top (
   input  logic i_clk,
   input  logic i_nrst,
   input  logic i_uart_rx,
   output logic o_uart_tx
);
   import ice51_pkg::*;

   logic               code_wr;
   logic [CODE_AW-1:0] code_waddr;
   logic [7:0]         code_wdata;
   logic [CODE_AW-1:0] code_raddr;
   logic [7:0]         code_rdata;
   logic               load_done;
   logic               tx_valid;
   logic [7:0]         tx_data;
   logic               tx_ready;

   cpu_if cpu_bus ();

   ////////////////////////////////////////////////////////////////////////////
   // boot path

   uart_loader uart_loader_inst (
      .i_clk        (i_clk),
      .i_nrst       (i_nrst),
      .i_uart_rx    (i_uart_rx),
      .o_code_wr    (code_wr),
      .o_code_addr  (code_waddr),
      .o_code_wdata (code_wdata),
      .o_load_done  (load_done)
   );

   code_ram code_ram_inst (
      .i_clk   (i_clk),
      .i_wr    (code_wr),
      .i_waddr (code_waddr),
      .i_wdata (code_wdata),
      .i_raddr (code_raddr),
      .o_rdata (code_rdata)
   );

   ////////////////////////////////////////////////////////////////////////////
   // core and transmitter

   cpu_sequencer cpu_sequencer_inst (
      .i_clk        (i_clk),
      .i_nrst       (i_nrst),
      .i_load_done  (load_done),
      .o_code_addr  (code_raddr),
      .i_code_rdata (code_rdata),
      .bus          (cpu_bus.seq)
   );

   cpu_datapath cpu_datapath_inst (
      .i_clk      (i_clk),
      .i_nrst     (i_nrst),
      .bus        (cpu_bus.dp),
      .o_tx_valid (tx_valid),
      .o_tx_data  (tx_data),
      .i_tx_ready (tx_ready)
   );

   uart_tx uart_tx_inst (
      .i_clk      (i_clk),
      .i_nrst     (i_nrst),
      .i_tx_valid (tx_valid),
      .i_tx_data  (tx_data),
      .o_tx_ready (tx_ready),
      .o_uart_tx  (o_uart_tx)
   );

endmodule

//--- verification/ice51_tb.sv
`timescale 1ns/1ns

module ice51_tb;
   import ice51_pkg::*;

   localparam int CLK_NS       = 20;
   localparam int SEED         = 80;
   localparam int NUM_TESTS    = 5;
   localparam int MARGIN_NS    = 200_000;
   localparam int FRAME_CYCLES = 10 * BIT_CYCLES;
   localparam int WATCHDOG_NS  =
      NUM_TESTS * (CODE_WORDS + 12) * FRAME_CYCLES * CLK_NS + MARGIN_NS;

   logic       clk;
   logic       nrst;
   logic       rx_line;          // serial into the dut
   logic       tx_line;          // serial out of the dut

   logic [7:0] prog[$];          // boot image being assembled
   logic [7:0] rx_q[$];          // frames decoded from tx_line
   int         fail_count   = 0;
   int         check_count  = 0;
   int         frame_errors = 0; // bad frames seen by the monitor
   int         idle_drops   = 0;
   bit         watch_idle   = 1'b0;

   ice51_top ice51_top_inst (
      .i_clk     (clk),
      .i_nrst    (nrst),
      .i_uart_rx (rx_line),
      .o_uart_tx (tx_line)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_NS / 2) clk = ~clk;
   end

   ////////////////////////////////////////////////////////////////////////////
   // checking and reporting

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      check_count++;
      if (expected !== actual) begin
         fail_count++;
         $display("CHECK FAILED %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
      end
   endtask

   task automatic report_test(input string name, input int fails_before);
      $display("test %-12s finished with %0d errors", name, fail_count - fails_before);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // program assembly

   task automatic emit(input logic [7:0] b);
      prog.push_back(b);
   endtask

   task automatic immediate(input logic [7:0] op, input logic [7:0] imm);
      prog.push_back(op);
      prog.push_back(imm);
   endtask

   task automatic point_dptr(input logic [15:0] addr);
      prog.push_back(OP_MOVDP);
      prog.push_back(addr[15:8]);    // high byte first
      prog.push_back(addr[7:0]);
   endtask

   // rel counts from the byte after the two byte branch
   task automatic resolve_branch(input int at, input int target);
      prog[at + 1] = 8'(target - (at + 2));
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // uart side

   task automatic drive_bit(input logic value);
      rx_line <= value;
      repeat (BIT_CYCLES) @(posedge clk);
   endtask

   task automatic send_byte(input logic [7:0] data);
      drive_bit(1'b0);
      for (int i = 0; i < 8; i++) drive_bit(data[i]);   // lsb first
      drive_bit(1'b1);
   endtask

   // pads with sjmp to itself, resets the dut and boots it
   task automatic load_program();
      int pad;
      pad = 0;
      while (prog.size() < CODE_WORDS) begin
         prog.push_back(pad[0] ? 8'hFE : OP_SJMP);
         pad++;
      end
      @(posedge clk);
      nrst    <= 1'b0;
      rx_line <= 1'b1;
      repeat (4) @(posedge clk);
      nrst <= 1'b1;
      repeat (4) @(posedge clk);
      foreach (prog[i]) send_byte(prog[i]);
   endtask

   task automatic receive_byte(output logic [7:0] data, output bit ok);
      ok   = 1'b0;
      data = 8'h00;
      @(negedge tx_line);
      repeat (BIT_CYCLES / 2) @(negedge clk);            // middle of start bit
      if (tx_line !== 1'b0) begin
         $display("ERROR: start bit on o_uart_tx ended before mid-bit");
         frame_errors++;
         return;
      end
      for (int i = 0; i < 8; i++) begin
         repeat (BIT_CYCLES) @(negedge clk);
         data[i] = tx_line;
      end
      repeat (BIT_CYCLES) @(negedge clk);
      if (tx_line !== 1'b1) begin
         $display("ERROR: frame 0x%0h on o_uart_tx has no stop bit", data);
         frame_errors++;
         return;
      end
      ok = 1'b1;
   endtask

   initial begin : frame_monitor
      logic [7:0] data;
      bit         ok;
      forever begin
         receive_byte(data, ok);
         if (ok) rx_q.push_back(data);
      end
   end

   always @(negedge clk) begin
      if (watch_idle && tx_line !== 1'b1) idle_drops++;
   end

   task automatic expect_frame(input string name, input logic [7:0] expected);
      int waited;
      waited = 0;
      while (rx_q.size() == 0 && waited < 3 * FRAME_CYCLES) begin
         @(posedge clk);
         waited++;
      end
      if (rx_q.size() == 0) begin
         $display("ERROR: %s waited for a frame on o_uart_tx but none arrived", name);
         fail_count++;
      end else begin
         check_value(name, {24'd0, expected}, {24'd0, rx_q.pop_front()});
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // directed tests

   task automatic test_idle_line();
      int fails_before;
      int drops_before;
      fails_before = fail_count;
      drops_before = idle_drops;
      prog.delete();                 // image is all padding
      watch_idle = 1'b1;
      load_program();
      repeat (2 * FRAME_CYCLES) @(posedge clk);
      watch_idle = 1'b0;
      check_value("idle_line", 0, idle_drops - drops_before);
      check_value("idle_frames", 0, rx_q.size());
      report_test("idle_line", fails_before);
   endtask

   task automatic test_arithmetic();
      int         fails_before;
      int         jc_at;
      int         sjmp_at;
      logic [7:0] x;
      logic [7:0] y;
      int         total;
      fails_before = fail_count;
      x     = 8'($urandom);
      y     = 8'($urandom);
      total = int'(x) + int'(y);
      prog.delete();
      immediate(OP_MOVAI, x);
      immediate(OP_ADDAI, y);
      point_dptr(TX_DATA_ADDR);
      emit(OP_MOVXDA);
      jc_at = prog.size();
      immediate(OP_JC, 8'h00);
      immediate(OP_MOVAI, 8'h00);    // no carry out
      sjmp_at = prog.size();
      immediate(OP_SJMP, 8'h00);
      resolve_branch(jc_at, prog.size());
      immediate(OP_MOVAI, 8'h01);
      resolve_branch(sjmp_at, prog.size());
      emit(OP_MOVXDA);
      load_program();
      expect_frame("arith_sum", 8'(total % 256));
      expect_frame("arith_carry", (total > 255) ? 8'h01 : 8'h00);
      report_test("arithmetic", fails_before);
   endtask

   task automatic test_logic();
      int         fails_before;
      logic [7:0] acc;
      logic [7:0] k_and;
      logic [7:0] k_or;
      logic [7:0] k_xor;
      logic [7:0] want[$];
      fails_before = fail_count;
      acc   = 8'($urandom);
      k_and = 8'($urandom);
      k_or  = 8'($urandom);
      k_xor = 8'($urandom);
      prog.delete();
      point_dptr(TX_DATA_ADDR);
      immediate(OP_MOVAI, acc);
      immediate(OP_ANLAI, k_and);
      emit(OP_MOVXDA);
      acc = acc & k_and;
      want.push_back(acc);
      immediate(OP_ORLA, k_or);
      emit(OP_MOVXDA);
      acc = acc | k_or;
      want.push_back(acc);
      immediate(OP_XRLA, k_xor);
      emit(OP_MOVXDA);
      acc = acc ^ k_xor;
      want.push_back(acc);
      emit(OP_CPLA);
      emit(OP_MOVXDA);
      acc = ~acc;
      want.push_back(acc);
      emit(OP_RL);
      emit(OP_MOVXDA);
      acc = {acc[6:0], acc[7]};      // no carry in the loop
      want.push_back(acc);
      emit(OP_SWAP);
      emit(OP_MOVXDA);
      acc = {acc[3:0], acc[7:4]};
      want.push_back(acc);
      emit(OP_INCA);
      emit(OP_MOVXDA);
      acc = acc + 8'd1;
      want.push_back(acc);
      emit(OP_DECA);
      emit(OP_MOVXDA);
      acc = acc - 8'd1;
      want.push_back(acc);
      emit(OP_CLRA);
      emit(OP_MOVXDA);
      want.push_back(8'h00);
      load_program();
      foreach (want[i]) expect_frame($sformatf("logic_step%0d", i), want[i]);
      report_test("logic", fails_before);
   endtask

   task automatic test_branches();
      int fails_before;
      int n;
      int loop_at;
      int jnz_at;
      int skip_at;
      fails_before = fail_count;
      n = 1 + int'($urandom % 5);
      prog.delete();
      point_dptr(TX_DATA_ADDR);
      immediate(OP_MOVAI, 8'(n));
      loop_at = prog.size();
      emit(OP_MOVXDA);
      emit(OP_DECA);
      jnz_at = prog.size();
      immediate(OP_JNZ, 8'h00);
      resolve_branch(jnz_at, loop_at);
      skip_at = prog.size();
      immediate(OP_SJMP, 8'h00);
      immediate(OP_MOVAI, 8'hAA);    // must never be sent
      emit(OP_MOVXDA);
      resolve_branch(skip_at, prog.size());
      immediate(OP_MOVAI, 8'h3C);
      emit(OP_MOVXDA);
      load_program();
      for (int i = n; i >= 1; i--) expect_frame("branch_loop", 8'(i));
      expect_frame("branch_skip", 8'h3C);
      report_test("branches", fails_before);
   endtask

   task automatic test_backpressure();
      int         fails_before;
      logic [7:0] x;
      logic [7:0] y;
      fails_before = fail_count;
      x = 8'($urandom);
      y = 8'($urandom);
      prog.delete();
      point_dptr(TX_DATA_ADDR);
      immediate(OP_MOVAI, x);
      emit(OP_MOVXDA);
      point_dptr(TX_STAT_ADDR);
      emit(OP_MOVXAD);               // transmitter still busy with x
      point_dptr(TX_DATA_ADDR);
      emit(OP_MOVXDA);               // stalls until x is out
      immediate(OP_MOVAI, y);
      emit(OP_MOVXDA);
      load_program();
      expect_frame("bp_first", x);
      expect_frame("bp_status", 8'h01);
      expect_frame("bp_second", y);
      report_test("backpressure", fails_before);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // run

   initial begin : main
      int seed_dummy;
      nrst    <= 1'b0;
      rx_line <= 1'b1;
      seed_dummy = $urandom(SEED);
      test_idle_line();
      test_arithmetic();
      test_logic();
      test_branches();
      test_backpressure();
      $display("%0d checks, %0d failed, %0d bad frames", check_count, fail_count,
               frame_errors);
      if (fail_count == 0 && frame_errors == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

   initial begin : watchdog
      #(WATCHDOG_NS);
      $display("ERROR: simulation still running after %0d ns", WATCHDOG_NS);
      $display("Checks failed");
      $finish;
   end

endmodule

//--- ice51.f
src/ice51_pkg.sv
src/cpu_if.sv
src/uart_loader.sv
src/code_ram.sv
src/cpu_sequencer.sv
src/cpu_datapath.sv
src/uart_tx.sv
src/ice51_top.sv
verification/ice51_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the ice51 testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
      -f ice51.f --top-module ice51_tb \
   && ./obj_dir/Vice51_tb | tee /dev/stderr | grep -qx "All checks passed" \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }
